// File: ahbApbSubsys.f
+incdir+.
ahbApbPkg.sv
apbBusIf.sv
ahbApbBridge.sv
apbDecoder.sv
apbRegBank.sv
bridgeProtocolMonitor.sv
ahbApbSubsys.sv
tbAhbApbSubsys.sv

// File: Bender.yml
package:
  name: ahbApbSubsys

sources:
  - include_dirs:
      - .
    files:
      - ahbApbPkg.sv
      - apbBusIf.sv
      - ahbApbBridge.sv
      - apbDecoder.sv
      - apbRegBank.sv
      - bridgeProtocolMonitor.sv
      - ahbApbSubsys.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbAhbApbSubsys.sv

// File: tbAhbApbSubsys.sv
/*
  Directed testbench for the AHB to APB subsystem with one transfer at a time.
  HREADY is looped back from HREADYOUT. HRESETn is active high.
*/
`timescale 1ns/10ps
`include "ahbApbBridge_macros.svh"

module tbAhbApbSubsys
    import ahbApbPkg::*;
();

    localparam int timeoutCycles = 32;

    logic      HCLK;
    logic      HRESETn;
    logic      HSEL;
    addrT      HADDR;
    htransE    HTRANS;
    logic      HWRITE;
    dataT      HWDATA;
    logic      HREADY;
    logic      HREADYOUT;
    hrespE     HRESP;
    dataT      HRDATA;
    violationT violations;

    // Reference model of both banks where offset 0 stays unused
    dataT shadow [0:1][0:`REG_WORDS-1];
    logic [31:0] lfsrState;
    int dataErrors;
    int respErrors;
    int latencyErrors;
    int violationErrors;
    int otherErrors;

    ahbApbSubsys i_ahbApbSubsys (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .HSEL       (HSEL),
        .HADDR      (HADDR),
        .HTRANS     (HTRANS),
        .HWRITE     (HWRITE),
        .HWDATA     (HWDATA),
        .HREADY     (HREADY),
        .HREADYOUT  (HREADYOUT),
        .HRESP      (HRESP),
        .HRDATA     (HRDATA),
        .violations (violations)
    );

    // Single completer on the bus
    assign HREADY = HREADYOUT;

    initial begin
        HCLK = 1'b0;
        forever #2 HCLK = ~HCLK;
    end

    // --------------------------------------------------
    // Random data and address helpers
    // --------------------------------------------------

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsrStep();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic dataT randomWord();
        dataT w;
        w = '0;
        for (int i = 0; i < `DATA_WIDTH; i++) begin
            w = {w[`DATA_WIDTH-2:0], lfsrStep()};
        end
        return w;
    endfunction

    function automatic addrT regAddr(input int slot, input int offset);
        return addrT'(slot) << `SLOT_LSB | addrT'(offset) << 2;
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------

    task automatic checkData(input string name, input dataT got, input dataT exp);
        if (got !== exp) begin
            dataErrors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkResp(input string name, input hrespE got, input hrespE exp);
        if (got !== exp) begin
            respErrors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkLatency(input string name, input int got, input int exp);
        if (got != exp) begin
            latencyErrors++;
            $display("[FAIL] %s cycles got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkViolations(input violationT got);
        if (got !== violationT'('0)) begin
            violationErrors++;
            $display("[FAIL] violations got 0x%h expected 0x%h", got, violationT'('0));
        end
    endtask

    // --------------------------------------------------
    // AHB driver
    // --------------------------------------------------

    // Address phase then data phase until HREADYOUT
    // Cycles count from edge N
    task automatic runTransfer(input addrT addr, input logic write, input dataT wdata,
                               output dataT rdata, output hrespE resp, output int cycles);
        @(negedge HCLK);
        HSEL   = 1'b1;
        HADDR  = addr;
        HTRANS = HTRANS_NONSEQ;
        HWRITE = write;
        @(negedge HCLK);
        // Data phase with HWDATA sampled at edge N+1
        HSEL   = 1'b0;
        HTRANS = HTRANS_IDLE;
        HWDATA = wdata;
        cycles = 1;
        while (HREADYOUT !== 1'b1 && cycles < timeoutCycles) begin
            @(negedge HCLK);
            cycles++;
        end
        if (HREADYOUT !== 1'b1) begin
            otherErrors++;
            $display("Transfer to address 0x%h never completed, HREADYOUT stuck low", addr);
        end
        rdata = HRDATA;
        resp  = HRESP;
    endtask

    task automatic ahbWrite(input addrT addr, input dataT data, output hrespE resp,
                            output int cycles);
        dataT unused;
        runTransfer(addr, 1'b1, data, unused, resp, cycles);
    endtask

    task automatic ahbRead(input addrT addr, output dataT data, output hrespE resp,
                           output int cycles);
        runTransfer(addr, 1'b0, randomWord(), data, resp, cycles);
    endtask

    // IDLE or BUSY must be answered zero-wait OKAY
    task automatic idleTransfer(input addrT addr, input htransE trans);
        @(negedge HCLK);
        HSEL   = 1'b1;
        HADDR  = addr;
        HTRANS = trans;
        HWRITE = 1'b1;
        @(negedge HCLK);
        HWDATA = randomWord();
        HSEL   = 1'b0;
        HTRANS = HTRANS_IDLE;
        if (HREADYOUT !== 1'b1) begin
            otherErrors++;
            $display("[FAIL] HREADYOUT idle got 0x%h expected 0x1", HREADYOUT);
        end
        checkResp("HRESP idle", HRESP, HRESP_OKAY);
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------

    task automatic testWriteReadBack();
        dataT rdata;
        hrespE resp;
        int cycles;
        for (int s = 0; s < 2; s++) begin
            for (int o = 1; o < `REG_WORDS; o++) begin
                shadow[s][o] = randomWord();
                ahbWrite(regAddr(s, o), shadow[s][o], resp, cycles);
                checkResp("HRESP write", resp, HRESP_OKAY);
            end
        end
        for (int s = 0; s < 2; s++) begin
            for (int o = 1; o < `REG_WORDS; o++) begin
                ahbRead(regAddr(s, o), rdata, resp, cycles);
                checkResp("HRESP read", resp, HRESP_OKAY);
                checkData("HRDATA", rdata, shadow[s][o]);
            end
        end
    endtask

    task automatic testSlaveErrors();
        dataT rdata;
        hrespE resp;
        int cycles;
        addrT rsvd;
        for (int s = 0; s < 2; s++) begin
            // ID word is read-only
            ahbWrite(regAddr(s, 0), randomWord(), resp, cycles);
            checkResp("HRESP id write", resp, HRESP_ERROR);
            ahbRead(regAddr(s, 0), rdata, resp, cycles);
            checkResp("HRESP id read", resp, HRESP_OKAY);
            checkData("HRDATA id", rdata, dataT'(`REG_BANK_ID) | dataT'(s));
            // Reserved bit 6 aliases offset 3
            rsvd = regAddr(s, 3) | addrT'(1) << `RSVD_LSB;
            ahbWrite(rsvd, randomWord(), resp, cycles);
            checkResp("HRESP rsvd write", resp, HRESP_ERROR);
            ahbRead(rsvd, rdata, resp, cycles);
            checkResp("HRESP rsvd read", resp, HRESP_ERROR);
            checkData("HRDATA rsvd", rdata, '0);
            ahbRead(regAddr(s, 3), rdata, resp, cycles);
            checkData("HRDATA after error", rdata, shadow[s][3]);
        end
    endtask

    task automatic testUnmapped();
        dataT rdata;
        hrespE resp;
        int cycles;
        int slots [3] = '{2, 5, 15};
        foreach (slots[i]) begin
            ahbWrite(regAddr(slots[i], 1), randomWord(), resp, cycles);
            checkResp("HRESP unmapped write", resp, HRESP_ERROR);
            ahbRead(regAddr(slots[i], 1), rdata, resp, cycles);
            checkResp("HRESP unmapped read", resp, HRESP_ERROR);
        end
    endtask

    task automatic testLatency();
        dataT rdata;
        hrespE resp;
        int cycles;
        shadow[0][4] = randomWord();
        ahbWrite(regAddr(0, 4), shadow[0][4], resp, cycles);
        checkLatency("slot0 write", cycles, 3);
        ahbRead(regAddr(0, 4), rdata, resp, cycles);
        checkLatency("slot0 read", cycles, 3);
        checkData("HRDATA latency", rdata, shadow[0][4]);
        ahbWrite(regAddr(0, 0), randomWord(), resp, cycles);
        checkLatency("slot0 error", cycles, 4);
        // Two wait states on slot 1
        ahbRead(regAddr(1, 4), rdata, resp, cycles);
        checkLatency("slot1 read", cycles, 3 + 2);
        ahbRead(regAddr(7, 4), rdata, resp, cycles);
        checkLatency("unmapped error", cycles, 4);
    endtask

    task automatic testIdleTransfers();
        dataT rdata;
        hrespE resp;
        int cycles;
        for (int s = 0; s < 2; s++) begin
            idleTransfer(regAddr(s, 5), HTRANS_IDLE);
            idleTransfer(regAddr(s, 5), HTRANS_BUSY);
            ahbRead(regAddr(s, 5), rdata, resp, cycles);
            checkData("HRDATA after idle", rdata, shadow[s][5]);
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        HRESETn = 1'b1;
        HSEL    = 1'b0;
        HADDR   = '0;
        HTRANS  = HTRANS_IDLE;
        HWRITE  = 1'b0;
        HWDATA  = '0;
        lfsrState = 32'h78fa_a0fb;
        dataErrors = 0;
        respErrors = 0;
        latencyErrors = 0;
        violationErrors = 0;
        otherErrors = 0;
        for (int s = 0; s < 2; s++) begin
            for (int o = 0; o < `REG_WORDS; o++) begin
                shadow[s][o] = '0;
            end
        end
        repeat (2) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b0;
        checkResp("HRESP reset", HRESP, HRESP_OKAY);
        checkViolations(violations);
        testWriteReadBack();
        checkViolations(violations);
        testSlaveErrors();
        checkViolations(violations);
        testUnmapped();
        checkViolations(violations);
        testLatency();
        checkViolations(violations);
        testIdleTransfers();
        checkViolations(violations);
        repeat (2) @(negedge HCLK);
        checkViolations(violations);
        $display("Errors: data %0d, resp %0d, latency %0d, violations %0d, other %0d",
                 dataErrors, respErrors, latencyErrors, violationErrors, otherErrors);
        if (dataErrors + respErrors + latencyErrors + violationErrors + otherErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: ahbApbSubsys.sv
/*
  AHB-Lite to APB subsystem with two register banks and a protocol monitor.
  HREADY comes in from outside so other completers can share the bus.
  HRESETn is synchronous and active high.
*/
`timescale 1ns/10ps
`include "ahbApbBridge_macros.svh"

module ahbApbSubsys
    import ahbApbPkg::*;
(
    input  logic      HCLK,
    input  logic      HRESETn,
    input  logic      HSEL,
    input  addrT      HADDR,
    input  htransE    HTRANS,
    input  logic      HWRITE,
    input  dataT      HWDATA,
    input  logic      HREADY,
    output logic      HREADYOUT,
    output hrespE     HRESP,
    output dataT      HRDATA,
    output violationT violations
);

    // Bridge to decoder, and one bus per peripheral slot
    apbBusIf apbMain ();
    apbBusIf apbSlot0 ();
    apbBusIf apbSlot1 ();

    ahbApbBridge i_bridge (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HWDATA    (HWDATA),
        .HREADY    (HREADY),
        .HREADYOUT (HREADYOUT),
        .HRESP     (HRESP),
        .HRDATA    (HRDATA),
        .apb       (apbMain.requester)
    );

    apbDecoder i_decoder (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .up      (apbMain.completer),
        .slot0   (apbSlot0.requester),
        .slot1   (apbSlot1.requester)
    );

    // Slot 0 zero wait, slot 1 with wait states
    apbRegBank #(.waitStates(`SLOT0_WAIT_STATES), .slotId(0)) i_bank0 (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .apb     (apbSlot0.completer)
    );

    apbRegBank #(.waitStates(`SLOT1_WAIT_STATES), .slotId(1)) i_bank1 (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .apb     (apbSlot1.completer)
    );

    bridgeProtocolMonitor i_monitor (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .apb        (apbMain.monitor),
        .HREADYOUT  (HREADYOUT),
        .HRESP      (HRESP),
        .violations (violations)
    );

endmodule

// File: bridgeProtocolMonitor.sv
/*
  Passive APB and bridge rule checker, no effect on timing.
  Each flag sets one edge after the offending cycle and holds until reset.
*/
`timescale 1ns/10ps

module bridgeProtocolMonitor
    import ahbApbPkg::*;
(
    input  logic      HCLK,
    input  logic      HRESETn,
    apbBusIf.monitor  apb,
    input  logic      HREADYOUT,
    input  hrespE     HRESP,
    output violationT violations
);

    // One-cycle history
    logic pselQ;
    logic penableQ;
    logic preadyQ;
    addrT paddrQ;
    logic pwriteQ;
    // Completer error seen last cycle
    logic slvErrQ;

    violationT hit;

    // ------------------------------------------------
    // Rule evaluation
    // ------------------------------------------------

    always_comb begin
        hit = '0;
        // PSEL must hold until PREADY
        hit.pselDropped     = pselQ && !preadyQ && !apb.psel;
        // SETUP last cycle, so ACCESS expected now
        hit.enableLate      = pselQ && !penableQ && !apb.penable;
        // PENABLE must hold until PREADY
        hit.enableDropped   = penableQ && !preadyQ && !apb.penable;
        hit.controlUnstable = pselQ && !preadyQ &&
                              ((apb.paddr != paddrQ) || (apb.pwrite != pwriteQ));
        // Waiting ACCESS must stall AHB, PSLVERR must become ERROR
        hit.respMismatch    = (apb.penable && !apb.pready && HREADYOUT) ||
                              (slvErrQ && (HRESP != HRESP_ERROR));
    end

    // ------------------------------------------------
    // History and sticky flags
    // ------------------------------------------------

    always_ff @(posedge HCLK) begin
        if (HRESETn) begin
            pselQ      <= 1'b0;
            penableQ   <= 1'b0;
            preadyQ    <= 1'b0;
            paddrQ     <= '0;
            pwriteQ    <= 1'b0;
            slvErrQ    <= 1'b0;
            violations <= '0;
        end else begin
            pselQ      <= apb.psel;
            penableQ   <= apb.penable;
            preadyQ    <= apb.pready;
            paddrQ     <= apb.paddr;
            pwriteQ    <= apb.pwrite;
            slvErrQ    <= apb.penable && apb.pready && apb.pslverr;
            violations <= violations | hit;
        end
    end

endmodule

// File: apbRegBank.sv
/*
  APB completer with REG_WORDS registers, offset 0 is a read-only ID.
  Writes to offset 0 or any access with bits 11:6 set give PSLVERR.
  waitStates cycles are inserted before PREADY in ACCESS.
*/
`timescale 1ns/10ps
`include "ahbApbBridge_macros.svh"

module apbRegBank
    import ahbApbPkg::*;
#(
    parameter int unsigned waitStates = `SLOT0_WAIT_STATES,
    parameter int unsigned slotId     = 0
) (
    input logic HCLK,
    input logic HRESETn,
    apbBusIf.completer apb
);

    localparam int unsigned cntWidth = (waitStates > 0) ? $clog2(waitStates + 1) : 1;
    localparam dataT idWord = `REG_BANK_ID | dataT'(slotId);

    dataT regQ [1:`REG_WORDS-1];
    logic [cntWidth-1:0] waitCntQ;
    logic [`REG_OFF_MSB-`REG_OFF_LSB:0] offset;
    logic access;
    logic waitDone;
    logic accessErr;

    assign offset = apb.paddr[`REG_OFF_MSB:`REG_OFF_LSB];
    assign access = apb.psel && apb.penable;

    // Reserved bits set, or write to the ID word
    assign accessErr = (|apb.paddr[`RSVD_MSB:`RSVD_LSB]) ||
                       (apb.pwrite && (offset == '0));

    // ------------------------------------------------
    // Wait-state counter
    // ------------------------------------------------

    assign waitDone = (waitCntQ == cntWidth'(waitStates));

    always_ff @(posedge HCLK) begin
        if (HRESETn) begin
            waitCntQ <= '0;
        end else if (access && !waitDone) begin
            waitCntQ <= waitCntQ + 1'b1;
        end else begin
            // Cleared on completion and between transfers
            waitCntQ <= '0;
        end
    end

    assign apb.pready  = access && waitDone;
    assign apb.pslverr = apb.pready && accessErr;

    // ------------------------------------------------
    // Register file
    // ------------------------------------------------

    always_ff @(posedge HCLK) begin
        if (HRESETn) begin
            for (int i = 1; i < `REG_WORDS; i++) begin
                regQ[i] <= '0;
            end
        end else if (apb.pready && apb.pwrite && !accessErr) begin
            regQ[offset] <= apb.pwdata;
        end
    end

    // Read path, zero on error
    always_comb begin
        if (accessErr) begin
            apb.prdata = '0;
        end else if (offset == '0) begin
            apb.prdata = idWord;
        end else begin
            apb.prdata = regQ[offset];
        end
    end

endmodule

// File: apbDecoder.sv
/*
  Routes one APB bus to NUM_SLOTS peers by PADDR bits 15:12.
  Unmapped slots are answered here with PREADY and PSLVERR in ACCESS.
*/
`timescale 1ns/10ps
`include "ahbApbBridge_macros.svh"

module apbDecoder (
    input logic HCLK,
    input logic HRESETn,
    apbBusIf.completer up,
    apbBusIf.requester slot0,
    apbBusIf.requester slot1
);

    localparam int slotBits = `SLOT_MSB - `SLOT_LSB + 1;

    logic [slotBits-1:0] slotD;
    logic [slotBits-1:0] slotQ;
    logic [slotBits-1:0] slotSel;
    logic setupPhase;
    logic mapped;

    // Decode live in SETUP, held copy afterwards
    assign slotD      = up.paddr[`SLOT_MSB:`SLOT_LSB];
    assign setupPhase = up.psel && !up.penable;
    assign slotSel    = setupPhase ? slotD : slotQ;
    assign mapped     = slotSel < slotBits'(`NUM_SLOTS);

    always_ff @(posedge HCLK) begin
        if (HRESETn) begin
            slotQ <= '0;
        end else if (setupPhase) begin
            slotQ <= slotD;
        end
    end

    // ------------------------------------------------
    // Request fan-out
    // ------------------------------------------------

    assign slot0.paddr   = up.paddr;
    assign slot0.pwrite  = up.pwrite;
    assign slot0.pwdata  = up.pwdata;
    assign slot0.penable = up.penable;
    assign slot0.psel    = up.psel && (slotSel == slotBits'(0));

    assign slot1.paddr   = up.paddr;
    assign slot1.pwrite  = up.pwrite;
    assign slot1.pwdata  = up.pwdata;
    assign slot1.penable = up.penable;
    assign slot1.psel    = up.psel && (slotSel == slotBits'(1));

    // ------------------------------------------------
    // Response mux
    // ------------------------------------------------

    always_comb begin
        if (!mapped) begin
            // Error reply in the first ACCESS cycle
            up.pready  = up.psel && up.penable;
            up.pslverr = up.psel && up.penable;
            up.prdata  = '0;
        end else if (slotSel == slotBits'(0)) begin
            up.pready  = slot0.pready;
            up.pslverr = slot0.pslverr;
            up.prdata  = slot0.prdata;
        end else begin
            up.pready  = slot1.pready;
            up.pslverr = slot1.pslverr;
            up.prdata  = slot1.prdata;
        end
    end

endmodule

// File: ahbApbBridge.sv
/*
  AHB-Lite completer for single transfers, APB requester on the far side.
  HREADYOUT stays low from SETUP to completion, one transfer in flight.
  HRESETn is synchronous and active high.
*/
`timescale 1ns/10ps

module ahbApbBridge
    import ahbApbPkg::*;
(
    input  logic   HCLK,
    input  logic   HRESETn,
    input  logic   HSEL,
    input  addrT   HADDR,
    input  htransE HTRANS,
    input  logic   HWRITE,
    input  dataT   HWDATA,
    input  logic   HREADY,
    output logic   HREADYOUT,
    output hrespE  HRESP,
    output dataT   HRDATA,
    apbBusIf.requester apb
);

    bridgeStateE stateQ;
    bridgeStateE stateD;

    // Captured address phase
    addrT haddrQ;
    logic hwriteQ;

    // Data phase payload
    dataT pwdataQ;
    dataT hrdataQ;

    logic accept;
    logic apbDone;

    // ------------------------------------------------
    // AHB side
    // ------------------------------------------------

    // Active transfer with the bus ready
    assign accept = HSEL && HREADY &&
                    ((HTRANS == HTRANS_NONSEQ) || (HTRANS == HTRANS_SEQ));

    // Ready in IDLE and in the second error cycle
    assign HREADYOUT = (stateQ == BR_IDLE) || (stateQ == BR_ERR2);
    assign HRESP     = ((stateQ == BR_ERR1) || (stateQ == BR_ERR2)) ? HRESP_ERROR
                                                                    : HRESP_OKAY;
    assign HRDATA    = hrdataQ;

    // ------------------------------------------------
    // APB side
    // ------------------------------------------------

    assign apbDone = (stateQ == BR_ACCESS) && apb.pready;

    assign apb.psel    = (stateQ == BR_SETUP) || (stateQ == BR_ACCESS);
    assign apb.penable = (stateQ == BR_ACCESS);
    assign apb.paddr   = haddrQ;
    assign apb.pwrite  = hwriteQ;
    // HWDATA is live in SETUP, the captured copy covers ACCESS
    assign apb.pwdata  = (stateQ == BR_SETUP) ? HWDATA : pwdataQ;

    // ------------------------------------------------
    // FSM
    // ------------------------------------------------

    always_comb begin
        stateD = stateQ;
        unique case (stateQ)
            BR_IDLE, BR_ERR2: begin
                // A new address phase may overlap the last ready cycle
                if (accept) begin
                    stateD = BR_SETUP;
                end else begin
                    stateD = BR_IDLE;
                end
            end
            BR_SETUP: begin
                stateD = BR_ACCESS;
            end
            BR_ACCESS: begin
                // Hold until the completer answers
                if (apb.pready) begin
                    stateD = apb.pslverr ? BR_ERR1 : BR_IDLE;
                end
            end
            BR_ERR1: begin
                stateD = BR_ERR2;
            end
            default: begin
                stateD = BR_IDLE;
            end
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (HRESETn) begin
            stateQ  <= BR_IDLE;
            haddrQ  <= '0;
            hwriteQ <= 1'b0;
        end else begin
            stateQ <= stateD;
            // Control stays frozen through wait states
            if (accept && HREADYOUT) begin
                haddrQ  <= HADDR;
                hwriteQ <= HWRITE;
            end
        end
    end

    // Payload registers
    always_ff @(posedge HCLK) begin
        if (stateQ == BR_SETUP) begin
            pwdataQ <= HWDATA;
        end
        // Read data returned on the ready cycle after completion
        if (apbDone && !hwriteQ) begin
            hrdataQ <= apb.prdata;
        end
    end

endmodule

// File: apbBusIf.sv
/*
  APB3 bus without PSTRB and PPROT.
  No clock inside, each user brings its own HCLK.
*/
`timescale 1ns/10ps

interface apbBusIf
    import ahbApbPkg::*;
();
    // Request side
    addrT paddr;
    logic psel;
    logic penable;
    logic pwrite;
    dataT pwdata;

    // Response side
    dataT prdata;
    logic pready;
    logic pslverr;

    modport requester (
        output paddr, psel, penable, pwrite, pwdata,
        input  prdata, pready, pslverr
    );

    modport completer (
        input  paddr, psel, penable, pwrite, pwdata,
        output prdata, pready, pslverr
    );

    // Observe only
    modport monitor (
        input paddr, psel, penable, pwrite, pwdata, prdata, pready, pslverr
    );

endinterface

// File: ahbApbPkg.sv
/*
  Types shared by the bridge, the decoder, the banks and the monitor.
  Widths come from the macros header.
*/
`include "ahbApbBridge_macros.svh"

package ahbApbPkg;

    // One bus word each
    typedef logic [`ADDR_WIDTH-1:0] addrT;
    typedef logic [`DATA_WIDTH-1:0] dataT;

    // AHB-Lite transfer type
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htransE;

    // Only OKAY and ERROR are used
    typedef enum logic [1:0] {
        HRESP_OKAY  = 2'b00,
        HRESP_ERROR = 2'b01
    } hrespE;

    // Bridge FSM
    typedef enum logic [2:0] {
        BR_IDLE,
        BR_SETUP,
        BR_ACCESS,
        BR_ERR1,
        BR_ERR2
    } bridgeStateE;

    // Sticky protocol violation flags
    typedef struct packed {
        logic pselDropped;
        logic enableLate;
        logic enableDropped;
        logic controlUnstable;
        logic respMismatch;
    } violationT;

endpackage

// File: ahbApbBridge_macros.svh
/*
  Shared widths and address map for the AHB to APB subsystem.
  Slot select uses address bits 15:12. Each bank decodes word offsets in bits 5:2.
*/
`ifndef AHB_APB_BRIDGE_MACROS_SVH
`define AHB_APB_BRIDGE_MACROS_SVH

// Bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// Peripheral slot select field of the address
`define SLOT_MSB 15
`define SLOT_LSB 12
`define NUM_SLOTS 2

// Register bank layout
`define REG_WORDS 16
`define REG_OFF_MSB 5
`define REG_OFF_LSB 2
// Reserved bits inside a slot, must be zero
`define RSVD_MSB 11
`define RSVD_LSB 6

// Read-only ID word at offset 0, slot index in the low bits
`define REG_BANK_ID 32'hA2B0_0000

// Wait-state defaults per slot
`define SLOT0_WAIT_STATES 0
`define SLOT1_WAIT_STATES 2

`endif
